// File: src/mem_pkg.sv
package mem_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int exp_w      = 7;   // one bit per cause

    // exception bit positions
    localparam int exp_ale  = 0;    // misaligned address
    localparam int exp_adem = 1;    // address out of range

    // width code 3 behaves as word
    localparam logic [1:0] width_byte = 2'd0;
    localparam logic [1:0] width_half = 2'd1;
    localparam logic [1:0] width_word = 2'd2;

    // ram geometry
    localparam int ram_words  = 256;
    localparam int line_bytes = 16;
    localparam int miss_extra = 3;   // extra cycles on a miss

    localparam int ram_idx_w  = $clog2(ram_words);
    localparam int line_sh    = $clog2(line_bytes);
    localparam int miss_cnt_w = $clog2(miss_extra + 1);

    localparam logic [miss_cnt_w-1:0] miss_last = miss_cnt_w'(miss_extra - 1);
    localparam logic [xlen-1:0]       ram_bytes = xlen'(ram_words * 4);

    // control carried from issue to response
    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [1:0]            width;
        logic                  sign;
        logic                  load;
        logic [1:0]            byte_off;
        logic [exp_w-1:0]      exp;
        logic [xlen-1:0]       addr;
    } mem_ctrl_t;

    // writeback payload
    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic [exp_w-1:0]      exp;
        logic [xlen-1:0]       badv;
    } wb_t;

endpackage

// File: src/mem_issue.sv
`timescale 1ns/1ps

module mem_issue (
    input  logic                             mem_en,
    input  logic                             mem_write,
    input  logic [1:0]                       mem_width,
    input  logic                             mem_sign,
    input  logic [mem_pkg::reg_addr_w-1:0]   mem_rd,
    input  logic [mem_pkg::xlen-1:0]         mem_base,
    input  logic [mem_pkg::xlen-1:0]         mem_imm,
    input  logic [mem_pkg::xlen-1:0]         mem_data,
    input  logic [mem_pkg::exp_w-1:0]        mem_exp,
    input  logic                             stall,
    output logic                             valid,
    output logic                             op,
    output logic [mem_pkg::xlen-1:0]         addr,
    output logic [mem_pkg::xlen/8-1:0]       write_type,
    output logic [mem_pkg::xlen-1:0]         w_data,
    output mem_pkg::mem_ctrl_t               ctrl
);
    logic [mem_pkg::xlen-1:0]     sum;
    logic [mem_pkg::xlen/8-1:0]   base_be;
    logic [mem_pkg::xlen/4-1:0]   be_twice;
    logic                         load_op;

    assign sum     = mem_base + mem_imm;
    assign load_op = mem_en & ~mem_write;

    assign valid = mem_en & ~stall;   // no request while the ram is busy
    assign op    = mem_write;
    assign addr  = sum;

    always_comb begin
        case (mem_width)
            mem_pkg::width_byte: base_be = 4'b0001;
            mem_pkg::width_half: base_be = 4'b0011;
            default:             base_be = 4'b1111;
        endcase
    end

    // rotate rather than shift, so a lane pattern that spills past the
    // word still shows its width to the ram alignment check
    assign be_twice   = {base_be, base_be} << sum[1:0];
    assign write_type = be_twice[mem_pkg::xlen/4-1:mem_pkg::xlen/8];

    always_comb begin
        case (mem_width)
            mem_pkg::width_byte: w_data = {(mem_pkg::xlen/8){mem_data[7:0]}};
            mem_pkg::width_half: w_data = {(mem_pkg::xlen/16){mem_data[15:0]}};
            default:             w_data = mem_data;
        endcase
    end

    always_comb begin
        ctrl.rd       = load_op ? mem_rd : '0;   // stores and bubbles write nothing
        ctrl.width    = mem_width;
        ctrl.sign     = mem_sign;
        ctrl.load     = load_op;
        ctrl.byte_off = sum[1:0];
        ctrl.exp      = mem_exp;
        ctrl.addr     = sum;
    end

endmodule

// File: src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid bit clears on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= in_valid;
        end
    end

    // payload follows the same load, holds otherwise
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    input  logic                          op,
    input  logic [mem_pkg::xlen-1:0]      addr,
    input  logic [mem_pkg::xlen/8-1:0]    write_type,
    input  logic [mem_pkg::xlen-1:0]      w_data,
    output logic                          data_valid,
    output logic [mem_pkg::xlen-1:0]      r_data,
    output logic [mem_pkg::exp_w-1:0]     cache_exp,
    output logic [mem_pkg::xlen-1:0]      cache_badv
);
    logic [mem_pkg::xlen-1:0]               mem [mem_pkg::ram_words];
    logic [mem_pkg::xlen-1:mem_pkg::line_sh] tag;
    logic                                   tag_valid;
    logic                                   hit;
    logic                                   aligned;
    logic [mem_pkg::exp_w-1:0]              req_exp;
    logic                                   pend;
    logic [mem_pkg::miss_cnt_w-1:0]         cnt;
    logic                                   p_op;
    logic [mem_pkg::xlen-1:0]               p_addr;
    logic [mem_pkg::xlen/8-1:0]             p_be;
    logic [mem_pkg::xlen-1:0]               p_data;
    logic                                   go;
    logic                                   a_op;
    logic [mem_pkg::xlen-1:0]               a_addr;
    logic [mem_pkg::xlen/8-1:0]             a_be;
    logic [mem_pkg::xlen-1:0]               a_data;
    logic [mem_pkg::ram_idx_w-1:0]          a_idx;

    // legal lane patterns for each width at this offset
    always_comb begin
        case (write_type)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: aligned = (write_type == (4'b0001 << addr[1:0]));
            4'b0011, 4'b1100:                   aligned = (write_type == (4'b0011 << addr[1:0]));
            4'b1111:                            aligned = (addr[1:0] == 2'b00);
            default:                            aligned = 1'b0;
        endcase
    end

    always_comb begin
        req_exp                   = '0;
        req_exp[mem_pkg::exp_ale]  = ~aligned;
        req_exp[mem_pkg::exp_adem] = (addr >= mem_pkg::ram_bytes);
    end

    assign hit = tag_valid && (tag == addr[mem_pkg::xlen-1:mem_pkg::line_sh]);

    // one access port fed by the new request or the finishing miss
    assign go     = (valid & ~(|req_exp) & hit) | (pend & (cnt == mem_pkg::miss_last));
    assign a_op   = pend ? p_op : op;
    assign a_addr = pend ? p_addr : addr;
    assign a_be   = pend ? p_be : write_type;
    assign a_data = pend ? p_data : w_data;
    assign a_idx  = a_addr[mem_pkg::ram_idx_w+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
            cache_exp  <= '0;
            pend       <= 1'b0;
            cnt        <= '0;
            tag_valid  <= 1'b0;
        end else begin
            data_valid <= go;
            cache_exp  <= valid ? req_exp : '0;   // exceptions never wait
            if (valid && !(|req_exp) && !hit) begin
                pend <= 1'b1;
                cnt  <= '0;
            end else if (pend) begin
                if (cnt == mem_pkg::miss_last) begin
                    pend      <= 1'b0;
                    tag_valid <= 1'b1;
                end
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            p_op       <= op;
            p_addr     <= addr;
            p_be       <= write_type;
            p_data     <= w_data;
            cache_badv <= addr;
        end
        if (pend && cnt == mem_pkg::miss_last) begin
            tag <= p_addr[mem_pkg::xlen-1:mem_pkg::line_sh];   // line now resident
        end
    end

    // a read returns the word before any write
    always_ff @(posedge clk) begin
        if (go) begin
            r_data <= mem[a_idx];
            if (a_op) begin
                for (int i = 0; i < mem_pkg::xlen / 8; i++) begin
                    if (a_be[i]) begin
                        mem[a_idx][8*i +: 8] <= a_data[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: src/mem_response.sv
`timescale 1ns/1ps

module mem_response (
    input  logic                         ctrl_valid,
    input  mem_pkg::mem_ctrl_t           ctrl,
    input  logic                         data_valid,
    input  logic [mem_pkg::xlen-1:0]     r_data,
    input  logic [mem_pkg::exp_w-1:0]    cache_exp,
    input  logic [mem_pkg::xlen-1:0]     cache_badv,
    output logic                         stall,
    output logic                         wb_load,
    output mem_pkg::wb_t                 wb
);
    logic                         ram_exc;
    logic                         done;
    logic [mem_pkg::exp_w-1:0]    exp;
    logic [mem_pkg::xlen-1:0]     shifted;
    logic [mem_pkg::xlen-1:0]     ext;

    assign ram_exc = |cache_exp;

    // waiting on the ram with nothing back yet
    assign stall   = ctrl_valid & ~(data_valid | ram_exc);
    assign done    = ctrl_valid & (data_valid | ram_exc);
    assign wb_load = done;

    assign exp = done ? (ctrl.exp | cache_exp) : '0;

    assign shifted = r_data >> {ctrl.byte_off, 3'b000};   // addressed lane to bit 0

    always_comb begin
        case (ctrl.width)
            mem_pkg::width_byte: begin
                ext = ctrl.sign ? {{(mem_pkg::xlen-8){shifted[7]}}, shifted[7:0]}
                                : {{(mem_pkg::xlen-8){1'b0}}, shifted[7:0]};
            end
            mem_pkg::width_half: begin
                ext = ctrl.sign ? {{(mem_pkg::xlen-16){shifted[15]}}, shifted[15:0]}
                                : {{(mem_pkg::xlen-16){1'b0}}, shifted[15:0]};
            end
            default: ext = shifted;
        endcase
    end

    always_comb begin
        wb     = '0;
        wb.exp = exp;
        if (done && exp == '0) begin
            wb.rd = ctrl.rd;   // already zero for stores
            if (ctrl.load) begin
                wb.data = ext;
            end
        end
        // ram fault address first, else the address of an upstream fault
        if (done && ram_exc) begin
            wb.badv = cache_badv;
        end else if (done && |ctrl.exp) begin
            wb.badv = ctrl.addr;
        end
    end

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             mem_en,
    input  logic                             mem_write,
    input  logic [1:0]                       mem_width,
    input  logic                             mem_sign,
    input  logic [mem_pkg::reg_addr_w-1:0]   mem_rd,
    input  logic [mem_pkg::xlen-1:0]         mem_base,
    input  logic [mem_pkg::xlen-1:0]         mem_imm,
    input  logic [mem_pkg::xlen-1:0]         mem_data,
    input  logic [mem_pkg::exp_w-1:0]        mem_exp,
    output logic                             mem_stall,
    output logic                             wb_valid,
    output logic [mem_pkg::reg_addr_w-1:0]   wb_rd,
    output logic [mem_pkg::xlen-1:0]         wb_data,
    output logic [mem_pkg::exp_w-1:0]        wb_exp,
    output logic [mem_pkg::xlen-1:0]         wb_badv
);
    logic                         valid;
    logic                         op;
    logic [mem_pkg::xlen-1:0]     addr;
    logic [mem_pkg::xlen/8-1:0]   write_type;
    logic [mem_pkg::xlen-1:0]     w_data;
    mem_pkg::mem_ctrl_t           ctrl_d;
    mem_pkg::mem_ctrl_t           ctrl_q;
    logic                         ctrl_valid;
    logic                         data_valid;
    logic [mem_pkg::xlen-1:0]     r_data;
    logic [mem_pkg::exp_w-1:0]    cache_exp;
    logic [mem_pkg::xlen-1:0]     cache_badv;
    logic                         wb_load;
    mem_pkg::wb_t                 wb_d;
    mem_pkg::wb_t                 wb_q;

    mem_issue issue_inst (
        .mem_en, .mem_write, .mem_width, .mem_sign, .mem_rd,
        .mem_base, .mem_imm, .mem_data, .mem_exp,
        .stall(mem_stall),
        .valid, .op, .addr, .write_type, .w_data,
        .ctrl(ctrl_d)
    );

    stage_reg #(.payload_t(mem_pkg::mem_ctrl_t)) issue_reg (
        .clk, .rst,
        .load(~mem_stall),   // holds the waiting instruction
        .in_valid(mem_en),
        .in_data(ctrl_d),
        .out_valid(ctrl_valid),
        .out_data(ctrl_q)
    );

    data_ram ram_inst (
        .clk, .rst, .valid, .op, .addr, .write_type, .w_data,
        .data_valid, .r_data, .cache_exp, .cache_badv
    );

    mem_response response_inst (
        .ctrl_valid, .ctrl(ctrl_q),
        .data_valid, .r_data, .cache_exp, .cache_badv,
        .stall(mem_stall), .wb_load, .wb(wb_d)
    );

    // loads every cycle so wb_valid is a one-cycle pulse
    stage_reg #(.payload_t(mem_pkg::wb_t)) wb_reg (
        .clk, .rst,
        .load(1'b1),
        .in_valid(wb_load),
        .in_data(wb_d),
        .out_valid(wb_valid),
        .out_data(wb_q)
    );

    assign wb_rd   = wb_q.rd;
    assign wb_data = wb_q.data;
    assign wb_exp  = wb_q.exp;
    assign wb_badv = wb_q.badv;

endmodule

// File: dv/mem_stage_properties.sv
`timescale 1ns/1ps

module mem_stage_properties (
    input logic                             clk,
    input logic                             rst,
    input logic                             mem_en,
    input logic                             mem_write,
    input logic [1:0]                       mem_width,
    input logic                             mem_sign,
    input logic [mem_pkg::reg_addr_w-1:0]   mem_rd,
    input logic [mem_pkg::xlen-1:0]         mem_base,
    input logic [mem_pkg::xlen-1:0]         mem_imm,
    input logic [mem_pkg::xlen-1:0]         mem_data,
    input logic [mem_pkg::exp_w-1:0]        mem_exp,
    input logic                             mem_stall,
    input logic                             wb_valid,
    input logic [mem_pkg::exp_w-1:0]        wb_exp
);
    int stall_run;   // stall cycles before the current one

    always_ff @(posedge clk) begin
        if (rst || !mem_stall) begin
            stall_run <= 0;
        end else begin
            stall_run <= stall_run + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) rst |=> !mem_stall && !wb_valid)
        else $error("mem_stall or wb_valid high right after reset");

    a_stall_ends: assert property (@(posedge clk) disable iff (rst)
        mem_stall |-> stall_run <= mem_pkg::miss_extra)
        else $error("mem_stall lasted longer than a miss");

    // upstream holds its instruction while the stage is busy
    a_upstream_held: assert property (@(posedge clk) disable iff (rst)
        mem_stall |=> $stable({mem_en, mem_write, mem_width, mem_sign, mem_rd,
                               mem_base, mem_imm, mem_data, mem_exp}))
        else $error("upstream inputs changed during a stall");

    a_idle_no_exp: assert property (@(posedge clk) disable iff (rst)
        !wb_valid |-> wb_exp == '0)
        else $error("wb_exp nonzero without wb_valid");

endmodule

// File: dv/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;
    localparam logic [31:0] win_base   = 32'h0000_0100;
    localparam int          win_bytes  = 64;   // four lines, so hits and misses mix
    localparam int          wait_limit = mem_pkg::miss_extra + 4;
    localparam int          random_ops = 300;

    logic                           clk;
    logic                           rst;
    logic                           mem_en;
    logic                           mem_write;
    logic [1:0]                     mem_width;
    logic                           mem_sign;
    logic [mem_pkg::reg_addr_w-1:0] mem_rd;
    logic [mem_pkg::xlen-1:0]       mem_base;
    logic [mem_pkg::xlen-1:0]       mem_imm;
    logic [mem_pkg::xlen-1:0]       mem_data;
    logic [mem_pkg::exp_w-1:0]      mem_exp;
    logic                           mem_stall;
    logic                           wb_valid;
    logic [mem_pkg::reg_addr_w-1:0] wb_rd;
    logic [mem_pkg::xlen-1:0]       wb_data;
    logic [mem_pkg::exp_w-1:0]      wb_exp;
    logic [mem_pkg::xlen-1:0]       wb_badv;

    logic [7:0]   ref_mem [mem_pkg::ram_words * 4];   // byte image of the ram
    mem_pkg::wb_t expected [$];
    logic [31:0]  lcg_state;
    logic         stall_last;   // mem_stall one cycle back

    mem_stage mem_stage_inst (.*);

    bind mem_stage mem_stage_properties props_inst (
        .clk, .rst, .mem_en, .mem_write, .mem_width, .mem_sign, .mem_rd,
        .mem_base, .mem_imm, .mem_data, .mem_exp, .mem_stall, .wb_valid, .wb_exp
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int access_bytes(input logic [1:0] width);
        return (width == mem_pkg::width_byte) ? 1 : (width == mem_pkg::width_half) ? 2 : 4;
    endfunction

    // bits raised by the ram itself
    function automatic logic [mem_pkg::exp_w-1:0] ram_fault(input logic [1:0] width,
                                                            input logic [31:0] addr);
        logic [mem_pkg::exp_w-1:0] e;
        e = '0;
        e[mem_pkg::exp_ale]  = (addr % access_bytes(width)) != 0;
        e[mem_pkg::exp_adem] = addr >= mem_pkg::ram_bytes;
        return e;
    endfunction

    function automatic mem_pkg::wb_t predict(input logic write, input logic [1:0] width,
            input logic sign, input logic [4:0] rd, input logic [31:0] addr,
            input logic [6:0] up_exp);
        mem_pkg::wb_t r;
        logic [31:0]  word;
        int           n;
        r = '0;
        r.exp = up_exp | ram_fault(width, addr);
        n = access_bytes(width);
        word = '0;
        if (r.exp != '0) begin
            r.badv = addr;   // faulting address, nothing else goes back
        end else if (!write) begin
            for (int i = 0; i < n; i++) begin
                word[8*i +: 8] = ref_mem[int'(addr) + i];
            end
            if (sign && n == 1) word = {{24{word[7]}}, word[7:0]};
            if (sign && n == 2) word = {{16{word[15]}}, word[15:0]};
            r.rd   = rd;
            r.data = word;
        end
        return r;
    endfunction

    task automatic apply_store(input logic [1:0] width, input logic [31:0] addr,
                               input logic [31:0] data);
        for (int i = 0; i < access_bytes(width); i++) begin
            ref_mem[int'(addr) + i] = data[8*i +: 8];
        end
    endtask

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("error: time %0t: %s is %h, expected %h", $time, what, got, want);
        abort_run();
    endtask

    task automatic broken_protocol(input string msg);
        $display("%s (at time %0t)", msg, $time);
        abort_run();
    endtask

    // drives one slot, holds it through any stall, returns after the accepting edge
    task automatic issue_op(input logic en, input logic write, input logic [1:0] width,
            input logic sign, input logic [4:0] rd, input logic [31:0] base,
            input logic [31:0] imm, input logic [31:0] data, input logic [6:0] up_exp);
        int waited;
        mem_en    = en;
        mem_write = write;
        mem_width = width;
        mem_sign  = sign;
        mem_rd    = rd;
        mem_base  = base;
        mem_imm   = imm;
        mem_data  = data;
        mem_exp   = up_exp;
        waited    = 0;
        while (mem_stall) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                broken_protocol("mem_stall never fell for a waiting load or store");
            end
        end
        if (en) begin
            expected.push_back(predict(write, width, sign, rd, base + imm, up_exp));
            if (write && ram_fault(width, base + imm) == '0) apply_store(width, base + imm, data);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic load_from(input logic [1:0] width, input logic sign,
                             input logic [31:0] addr, input logic [6:0] up_exp);
        issue_op(1'b1, 1'b0, width, sign, 5'(next_rand() >> 27), addr + 32'd4,
                 32'hffff_fffc, 32'h0, up_exp);
    endtask

    task automatic store_to(input logic [1:0] width, input logic [31:0] addr,
                            input logic [31:0] data);
        issue_op(1'b1, 1'b1, width, 1'b0, 5'(next_rand() >> 27), addr - 32'd8, 32'd8, data, '0);
    endtask

    // every writeback is checked against the oldest accepted instruction
    always @(negedge clk) begin
        mem_pkg::wb_t want;
        if (!rst && wb_valid) begin
            assert (expected.size() != 0)
                else broken_protocol("wb_valid with no instruction outstanding");
            assert (!stall_last)
                else broken_protocol("an instruction completed while mem_stall was high");
            want = expected.pop_front();
            assert (wb_rd == want.rd) else flag_mismatch("wb_rd", 32'(wb_rd), 32'(want.rd));
            assert (wb_data == want.data) else flag_mismatch("wb_data", wb_data, want.data);
            assert (wb_exp == want.exp) else flag_mismatch("wb_exp", 32'(wb_exp), 32'(want.exp));
            assert (wb_badv == want.badv) else flag_mismatch("wb_badv", wb_badv, want.badv);
        end
        stall_last = !rst && mem_stall;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [6:0]  up_exp;
        int          waited;
        rst        = 1'b1;
        mem_en     = 1'b0;
        mem_write  = 1'b0;
        mem_width  = mem_pkg::width_word;
        mem_sign   = 1'b0;
        mem_rd     = '0;
        mem_base   = '0;
        mem_imm    = '0;
        mem_data   = '0;
        mem_exp    = '0;
        lcg_state  = 32'd62;
        stall_last = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // known contents for the whole window first
        for (int i = 0; i < win_bytes; i += 4) begin
            store_to(mem_pkg::width_word, win_base + i, next_rand());
        end
        store_to(mem_pkg::width_word, win_base + 8, 32'hcafe_f00d);
        load_from(mem_pkg::width_word, 1'b0, win_base + 8, '0);

        for (int i = 0; i < 4; i++) begin
            store_to(mem_pkg::width_byte, win_base + 16 + i, 32'h70 + 32'(i) * 32'h11);
            load_from(mem_pkg::width_word, 1'b0, win_base + 16, '0);
            load_from(mem_pkg::width_byte, 1'b1, win_base + 16 + i, '0);
            load_from(mem_pkg::width_byte, 1'b0, win_base + 16 + i, '0);
        end
        for (int i = 0; i < 4; i += 2) begin
            store_to(mem_pkg::width_half, win_base + 20 + i, 32'h7f00 + 32'(i) * 32'h4000);
            load_from(mem_pkg::width_word, 1'b0, win_base + 20, '0);
            load_from(mem_pkg::width_half, 1'b1, win_base + 20 + i, '0);
            load_from(mem_pkg::width_half, 1'b0, win_base + 20 + i, '0);
        end

        // misaligned accesses leave memory alone
        store_to(mem_pkg::width_half, win_base + 33, 32'h0000_aaaa);
        store_to(mem_pkg::width_half, win_base + 35, 32'h0000_bbbb);
        for (int i = 1; i < 4; i++) store_to(2'd3 - 2'(i & 1), win_base + 36 + i, 32'hdead_beef);
        load_from(mem_pkg::width_word, 1'b0, win_base + 34, '0);
        load_from(mem_pkg::width_word, 1'b0, win_base + 32, '0);
        load_from(mem_pkg::width_word, 1'b0, win_base + 36, '0);

        // out of range, and upstream bits merged in
        load_from(mem_pkg::width_word, 1'b0, mem_pkg::ram_bytes, '0);
        store_to(mem_pkg::width_word, mem_pkg::ram_bytes + 4, 32'h1234_5678);
        load_from(mem_pkg::width_half, 1'b1, mem_pkg::ram_bytes + 1, '0);
        load_from(mem_pkg::width_byte, 1'b0, 32'hffff_fff0, '0);
        load_from(mem_pkg::width_word, 1'b0, win_base, 7'b001_0100);
        load_from(mem_pkg::width_byte, 1'b0, mem_pkg::ram_bytes + 2, 7'b100_0000);

        // bubbles carrying store-like junk
        for (int i = 0; i < 6; i++) begin
            issue_op(1'b0, 1'b1, mem_pkg::width_word, 1'b0, 5'd3, win_base, 32'(i * 4),
                     32'hffff_ffff, '0);
        end
        load_from(mem_pkg::width_word, 1'b0, win_base, '0);
        load_from(mem_pkg::width_word, 1'b0, win_base + 20, '0);

        for (int n = 0; n < random_ops; n++) begin
            r = next_rand();
            addr = win_base + 32'(next_rand() >> 16) % win_bytes;
            if (r[15:12] == 4'd0) addr = mem_pkg::ram_bytes + 32'(r[11:6]);
            up_exp = (!r[28] && r[5:2] == 4'd0) ? (7'(r[22:16]) & 7'h7c) : 7'h00;
            issue_op(r[31:29] != 3'd0, r[28], r[27:26], r[25], r[24:20], addr - 32'h40,
                     32'h40, next_rand(), up_exp);
        end

        mem_en = 1'b0;
        waited = 0;
        while (expected.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) broken_protocol("writebacks stopped with instructions left");
        end
        repeat (4) @(posedge clk);   // no stray writeback after the last one
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: mem_stage.f
src/mem_pkg.sv
src/mem_issue.sv
src/stage_reg.sv
src/data_ram.sv
src/mem_response.sv
src/mem_stage.sv
dv/mem_stage_properties.sv
dv/mem_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mem_stage testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_stage_tb -Mdir obj_dir -f mem_stage.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmem_stage_tb > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
